// File: run.sh
#!/bin/sh
# Build the receive buffer testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -j 0 \
    -f verilog.f --top-module tb_rx_buf -o tb_rx_buf
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rx_buf > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
exit 1

// File: rx_buf_data_ram.sv
`timescale 1ns/100ps

module rx_buf_data_ram (
     input  logic                  clk

    ,input  logic                  wr_en
    ,input  rx_buf_pkg::buf_addr_t wr_addr
    ,input  rx_buf_pkg::mac_data_t wr_data

    ,input  rx_buf_pkg::buf_addr_t rd_addr
    ,output rx_buf_pkg::mac_data_t rd_data
);

    rx_buf_pkg::mac_data_t mem [rx_buf_pkg::BUF_DEPTH];

    // Whole-word writes only.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Data follows the address by one cycle.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rx_buf_desc_fifo.sv
`timescale 1ns/100ps

module rx_buf_desc_fifo (
     input  logic                  clk
    ,input  logic                  rst

    ,input  logic                  enq_valid
    ,output logic                  enq_ready
    ,input  rx_buf_pkg::conn_id_t  enq_conn_id
    ,input  rx_buf_pkg::head_ptr_t enq_head_ptr

    ,output logic                  desc_valid
    ,input  logic                  desc_ready
    ,output rx_buf_pkg::conn_id_t  desc_conn_id
    ,output rx_buf_pkg::head_ptr_t desc_head_ptr
);

    rx_buf_pkg::conn_id_t                 conn_id_mem  [rx_buf_pkg::DESC_FIFO_DEPTH];
    rx_buf_pkg::head_ptr_t                head_ptr_mem [rx_buf_pkg::DESC_FIFO_DEPTH];
    logic [rx_buf_pkg::DESC_FIFO_IDX_W-1:0] wr_idx;
    logic [rx_buf_pkg::DESC_FIFO_IDX_W-1:0] rd_idx;
    logic [rx_buf_pkg::DESC_FIFO_IDX_W:0]   count;
    logic                                 push;
    logic                                 pop;

    assign enq_ready = (count != (rx_buf_pkg::DESC_FIFO_IDX_W+1)'(rx_buf_pkg::DESC_FIFO_DEPTH));
    assign desc_valid = (count != '0);

    assign push = enq_valid & enq_ready;
    assign pop = desc_valid & desc_ready;

    assign desc_conn_id = conn_id_mem[rd_idx];
    assign desc_head_ptr = head_ptr_mem[rd_idx];

    always_ff @(posedge clk) begin
        if (push) begin
            conn_id_mem[wr_idx] <= enq_conn_id;
            head_ptr_mem[wr_idx] <= enq_head_ptr;
        end
    end

    // Indices wrap on their own width.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rx_buf_input_ctrl.sv
`timescale 1ns/100ps

module rx_buf_input_ctrl (
     input  logic                    clk
    ,input  logic                    rst

    ,input  logic                    in_valid
    ,output logic                    in_ready
    ,input  logic                    in_conn_open
    ,input  logic                    in_last

    ,output logic                    store_meta
    ,output logic                    store_ptrs
    ,output rx_buf_pkg::rx_ptr_sel_e ptr_sel
    ,output logic                    incr_head_ptr
    ,input  logic                    ptrs_stored

    ,output logic                    buf_wr_en
    ,output logic                    ptr_wr_en

    ,output logic                    enq_valid
    ,input  logic                    enq_ready
);

    rx_buf_pkg::input_ctrl_state_e state_reg;
    rx_buf_pkg::input_ctrl_state_e state_next;
    logic                          open_reg;
    logic                          open_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= rx_buf_pkg::IDLE;
            open_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            open_reg <= open_next;
        end
    end

    always_comb begin
        state_next = state_reg;
        open_next = open_reg;

        in_ready = 1'b0;
        store_meta = 1'b0;
        store_ptrs = 1'b0;
        ptr_sel = rx_buf_pkg::PTR_SEL_LOADED;
        incr_head_ptr = 1'b0;
        buf_wr_en = 1'b0;
        ptr_wr_en = 1'b0;
        enq_valid = 1'b0;

        case (state_reg)
            rx_buf_pkg::IDLE: begin
                // Capture metadata, pointer RAM read starts now.
                if (in_valid) begin
                    store_meta = 1'b1;
                    open_next = in_conn_open;
                    state_next = rx_buf_pkg::DATA;
                end
            end
            rx_buf_pkg::DATA: begin
                in_ready = 1'b1;
                if (in_valid) begin
                    incr_head_ptr = 1'b1;
                    buf_wr_en = 1'b1;
                    ptr_wr_en = 1'b1;
                    // First beat of the message picks the pointer source.
                    if (!ptrs_stored) begin
                        store_ptrs = 1'b1;
                        ptr_sel = open_reg ? rx_buf_pkg::PTR_SEL_CLEAR
                                           : rx_buf_pkg::PTR_SEL_LOADED;
                    end
                    if (in_last) begin
                        state_next = rx_buf_pkg::ENQ;
                    end
                end
            end
            rx_buf_pkg::ENQ: begin
                // Full FIFO holds us here and stalls the next message.
                enq_valid = 1'b1;
                if (enq_ready) begin
                    state_next = rx_buf_pkg::IDLE;
                end
            end
            default: begin
                state_next = rx_buf_pkg::IDLE;
            end
        endcase
    end

endmodule

// File: rx_buf_input_datap.sv
`timescale 1ns/100ps

module rx_buf_input_datap (
     input  logic                    clk
    ,input  logic                    rst

    ,input  rx_buf_pkg::conn_id_t    in_conn_id
    ,input  rx_buf_pkg::mac_data_t   in_data
    ,input  logic                    in_last
    ,input  rx_buf_pkg::padbytes_t   in_padbytes

    ,input  logic                    store_meta
    ,input  logic                    store_ptrs
    ,input  rx_buf_pkg::rx_ptr_sel_e ptr_sel
    ,input  logic                    incr_head_ptr
    ,output logic                    ptrs_stored

    ,output rx_buf_pkg::conn_id_t    ptr_rd_addr
    ,input  rx_buf_pkg::head_ptr_t   ptr_rd_data
    ,output rx_buf_pkg::conn_id_t    ptr_wr_addr
    ,output rx_buf_pkg::head_ptr_t   ptr_wr_data

    ,output rx_buf_pkg::buf_addr_t   buf_wr_addr
    ,output rx_buf_pkg::mac_data_t   buf_wr_data

    ,output rx_buf_pkg::conn_id_t    enq_conn_id
    ,output rx_buf_pkg::head_ptr_t   enq_head_ptr
);

    rx_buf_pkg::conn_id_t  conn_id_reg;
    rx_buf_pkg::conn_id_t  conn_id_next;
    rx_buf_pkg::head_ptr_t head_ptr_reg;
    rx_buf_pkg::head_ptr_t head_ptr_mux;
    rx_buf_pkg::head_ptr_t head_ptr_incr;
    rx_buf_pkg::head_ptr_t head_ptr_next;
    logic                  ptrs_stored_reg;
    logic                  ptrs_stored_next;

    assign conn_id_next = store_meta ? in_conn_id : conn_id_reg;

    // Read address is live in the metadata cycle.
    assign ptr_rd_addr = conn_id_next;
    assign ptr_wr_addr = conn_id_reg;
    assign ptr_wr_data = head_ptr_next;

    // Word index of the pointer before this beat advances it.
    assign buf_wr_addr = {conn_id_reg, head_ptr_mux[rx_buf_pkg::HEAD_PTR_W-1:rx_buf_pkg::BYTE_OFF_W]};
    assign buf_wr_data = in_data;

    assign enq_conn_id = conn_id_reg;
    assign enq_head_ptr = head_ptr_reg;

    assign ptrs_stored = ptrs_stored_reg;

    always_comb begin
        if (store_ptrs) begin
            head_ptr_mux = (ptr_sel == rx_buf_pkg::PTR_SEL_CLEAR) ? '0 : ptr_rd_data;
        end else begin
            head_ptr_mux = head_ptr_reg;
        end
    end

    // Last beat drops its pad bytes from the advance.
    assign head_ptr_incr = in_last
        ? rx_buf_pkg::head_ptr_t'(rx_buf_pkg::MAC_BYTES) - rx_buf_pkg::head_ptr_t'(in_padbytes)
        : rx_buf_pkg::head_ptr_t'(rx_buf_pkg::MAC_BYTES);

    // Wraps within the connection region.
    assign head_ptr_next = incr_head_ptr ? head_ptr_mux + head_ptr_incr : head_ptr_mux;

    always_comb begin
        if (store_meta) begin
            ptrs_stored_next = 1'b0;
        end else if (store_ptrs) begin
            ptrs_stored_next = 1'b1;
        end else begin
            ptrs_stored_next = ptrs_stored_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptrs_stored_reg <= 1'b0;
        end else begin
            ptrs_stored_reg <= ptrs_stored_next;
        end
    end

    always_ff @(posedge clk) begin
        conn_id_reg <= conn_id_next;
        head_ptr_reg <= head_ptr_next;
    end

endmodule

// File: rx_buf_pkg.sv
package rx_buf_pkg;

    // Stream beat geometry.
    localparam int MAC_BYTES  = 8;
    localparam int MAC_DATA_W = 64;
    localparam int PADBYTES_W = 3;

    // Byte offset bits within one beat.
    localparam int BYTE_OFF_W = 3;

    // Connections and per-connection region.
    localparam int CONN_ID_W  = 3;
    localparam int NUM_CONNS  = 2 ** CONN_ID_W;
    localparam int HEAD_PTR_W = 9;

    // Buffer word address is connection id over the word index.
    localparam int BUF_ADDR_W = CONN_ID_W + HEAD_PTR_W - BYTE_OFF_W;
    localparam int BUF_DEPTH  = 2 ** BUF_ADDR_W;

    // Descriptor queue.
    localparam int DESC_FIFO_IDX_W = 2;
    localparam int DESC_FIFO_DEPTH = 2 ** DESC_FIFO_IDX_W;

    typedef logic [CONN_ID_W-1:0]  conn_id_t;
    typedef logic [MAC_DATA_W-1:0] mac_data_t;
    typedef logic [PADBYTES_W-1:0] padbytes_t;
    typedef logic [HEAD_PTR_W-1:0] head_ptr_t;
    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

    // Where the working head pointer comes from on the first beat.
    typedef enum logic [0:0] {
        PTR_SEL_LOADED,
        PTR_SEL_CLEAR
    } rx_ptr_sel_e;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        ENQ
    } input_ctrl_state_e;

endpackage

// File: rx_buf_ptr_ram.sv
`timescale 1ns/100ps

module rx_buf_ptr_ram (
     input  logic                  clk

    ,input  rx_buf_pkg::conn_id_t  rd_addr
    ,output rx_buf_pkg::head_ptr_t rd_data

    ,input  logic                  wr_en
    ,input  rx_buf_pkg::conn_id_t  wr_addr
    ,input  rx_buf_pkg::head_ptr_t wr_data
);

    // One head pointer per connection.
    rx_buf_pkg::head_ptr_t mem [rx_buf_pkg::NUM_CONNS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, old data on a same-address write.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rx_buf_top.sv
`timescale 1ns/100ps

module rx_buf_top (
     input  logic                  clk
    ,input  logic                  rst

    ,input  logic                  in_valid
    ,output logic                  in_ready
    ,input  rx_buf_pkg::conn_id_t  in_conn_id
    ,input  logic                  in_conn_open
    ,input  rx_buf_pkg::mac_data_t in_data
    ,input  logic                  in_last
    ,input  rx_buf_pkg::padbytes_t in_padbytes

    ,output logic                  desc_valid
    ,input  logic                  desc_ready
    ,output rx_buf_pkg::conn_id_t  desc_conn_id
    ,output rx_buf_pkg::head_ptr_t desc_head_ptr

    ,input  rx_buf_pkg::buf_addr_t buf_rd_addr
    ,output rx_buf_pkg::mac_data_t buf_rd_data
);

    logic                    store_meta;
    logic                    store_ptrs;
    rx_buf_pkg::rx_ptr_sel_e ptr_sel;
    logic                    incr_head_ptr;
    logic                    ptrs_stored;

    rx_buf_pkg::conn_id_t    ptr_rd_addr;
    rx_buf_pkg::head_ptr_t   ptr_rd_data;
    logic                    ptr_wr_en;
    rx_buf_pkg::conn_id_t    ptr_wr_addr;
    rx_buf_pkg::head_ptr_t   ptr_wr_data;

    logic                    buf_wr_en;
    rx_buf_pkg::buf_addr_t   buf_wr_addr;
    rx_buf_pkg::mac_data_t   buf_wr_data;

    logic                    enq_valid;
    logic                    enq_ready;
    rx_buf_pkg::conn_id_t    enq_conn_id;
    rx_buf_pkg::head_ptr_t   enq_head_ptr;

    rx_buf_input_ctrl input_ctrl_i (
         .clk           (clk)
        ,.rst           (rst)
        ,.in_valid      (in_valid)
        ,.in_ready      (in_ready)
        ,.in_conn_open  (in_conn_open)
        ,.in_last       (in_last)
        ,.store_meta    (store_meta)
        ,.store_ptrs    (store_ptrs)
        ,.ptr_sel       (ptr_sel)
        ,.incr_head_ptr (incr_head_ptr)
        ,.ptrs_stored   (ptrs_stored)
        ,.buf_wr_en     (buf_wr_en)
        ,.ptr_wr_en     (ptr_wr_en)
        ,.enq_valid     (enq_valid)
        ,.enq_ready     (enq_ready)
    );

    rx_buf_input_datap input_datap_i (
         .clk           (clk)
        ,.rst           (rst)
        ,.in_conn_id    (in_conn_id)
        ,.in_data       (in_data)
        ,.in_last       (in_last)
        ,.in_padbytes   (in_padbytes)
        ,.store_meta    (store_meta)
        ,.store_ptrs    (store_ptrs)
        ,.ptr_sel       (ptr_sel)
        ,.incr_head_ptr (incr_head_ptr)
        ,.ptrs_stored   (ptrs_stored)
        ,.ptr_rd_addr   (ptr_rd_addr)
        ,.ptr_rd_data   (ptr_rd_data)
        ,.ptr_wr_addr   (ptr_wr_addr)
        ,.ptr_wr_data   (ptr_wr_data)
        ,.buf_wr_addr   (buf_wr_addr)
        ,.buf_wr_data   (buf_wr_data)
        ,.enq_conn_id   (enq_conn_id)
        ,.enq_head_ptr  (enq_head_ptr)
    );

    rx_buf_ptr_ram ptr_ram_i (
         .clk     (clk)
        ,.rd_addr (ptr_rd_addr)
        ,.rd_data (ptr_rd_data)
        ,.wr_en   (ptr_wr_en)
        ,.wr_addr (ptr_wr_addr)
        ,.wr_data (ptr_wr_data)
    );

    rx_buf_data_ram data_ram_i (
         .clk     (clk)
        ,.wr_en   (buf_wr_en)
        ,.wr_addr (buf_wr_addr)
        ,.wr_data (buf_wr_data)
        ,.rd_addr (buf_rd_addr)
        ,.rd_data (buf_rd_data)
    );

    rx_buf_desc_fifo desc_fifo_i (
         .clk           (clk)
        ,.rst           (rst)
        ,.enq_valid     (enq_valid)
        ,.enq_ready     (enq_ready)
        ,.enq_conn_id   (enq_conn_id)
        ,.enq_head_ptr  (enq_head_ptr)
        ,.desc_valid    (desc_valid)
        ,.desc_ready    (desc_ready)
        ,.desc_conn_id  (desc_conn_id)
        ,.desc_head_ptr (desc_head_ptr)
    );

endmodule

// File: tb_rx_buf.sv
`timescale 1ns/100ps

module tb_rx_buf;

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_MSGS    = 200;
    localparam int MAX_BEATS   = 6;
    localparam int WATCHDOG_NS = NUM_MSGS * MAX_BEATS * 40 * CLK_PERIOD + 10000;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    rx_buf_pkg::conn_id_t  in_conn_id;
    logic                  in_conn_open;
    rx_buf_pkg::mac_data_t in_data;
    logic                  in_last;
    rx_buf_pkg::padbytes_t in_padbytes;
    logic                  desc_valid;
    logic                  desc_ready;
    rx_buf_pkg::conn_id_t  desc_conn_id;
    rx_buf_pkg::head_ptr_t desc_head_ptr;
    rx_buf_pkg::buf_addr_t buf_rd_addr;
    rx_buf_pkg::mac_data_t buf_rd_data;

    // Reference model.
    rx_buf_pkg::head_ptr_t model_ptr [rx_buf_pkg::NUM_CONNS];
    bit                    conn_seen [rx_buf_pkg::NUM_CONNS];
    rx_buf_pkg::mac_data_t image     [rx_buf_pkg::BUF_DEPTH];
    bit                    written   [rx_buf_pkg::BUF_DEPTH];
    rx_buf_pkg::conn_id_t  exp_conn_q [$];
    rx_buf_pkg::head_ptr_t exp_ptr_q  [$];

    int completed = 0;
    int popped = 0;
    int full_cycles = 0;
    bit draining = 1'b0;

    rx_buf_top dut_i (
         .clk           (clk)
        ,.rst           (rst)
        ,.in_valid      (in_valid)
        ,.in_ready      (in_ready)
        ,.in_conn_id    (in_conn_id)
        ,.in_conn_open  (in_conn_open)
        ,.in_data       (in_data)
        ,.in_last       (in_last)
        ,.in_padbytes   (in_padbytes)
        ,.desc_valid    (desc_valid)
        ,.desc_ready    (desc_ready)
        ,.desc_conn_id  (desc_conn_id)
        ,.desc_head_ptr (desc_head_ptr)
        ,.buf_rd_addr   (buf_rd_addr)
        ,.buf_rd_data   (buf_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_desc(rx_buf_pkg::conn_id_t got_conn, rx_buf_pkg::head_ptr_t got_ptr);
        rx_buf_pkg::conn_id_t  exp_conn;
        rx_buf_pkg::head_ptr_t exp_ptr;
        if (exp_conn_q.size() == 0) begin
            $display("A descriptor for connection %0d arrived with none expected.", got_conn);
            abort_run();
        end else begin
            exp_conn = exp_conn_q.pop_front();
            exp_ptr = exp_ptr_q.pop_front();
            if (got_conn !== exp_conn || got_ptr !== exp_ptr) begin
                $display("** Error at time %0t: got conn %0d ptr %0d, expected conn %0d ptr %0d",
                         $time, got_conn, got_ptr, exp_conn, exp_ptr);
                abort_run();
            end
        end
    endtask

    task automatic check_word(rx_buf_pkg::buf_addr_t addr, rx_buf_pkg::mac_data_t got);
        if (got !== image[addr]) begin
            $display("** Error at time %0t: buffer word %0d read %h, expected %h",
                     $time, addr, got, image[addr]);
            abort_run();
        end
    endtask

    task automatic check_ready(logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at time %0t: in_ready is %b with the FIFO full, expected %b",
                     $time, got, exp);
            abort_run();
        end
    endtask

    // Entered 1 ns after a rising edge and left 1 ns after the edge that takes the beat.
    task automatic send_beat(rx_buf_pkg::conn_id_t conn, logic open_flag,
                             rx_buf_pkg::mac_data_t data, logic last, rx_buf_pkg::padbytes_t pad);
        logic taken;
        if ($urandom % 100 < 20) begin
            in_valid = 1'b0;
            repeat (1 + $urandom % 3) @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_conn_id = conn;
        in_conn_open = open_flag;
        in_data = data;
        in_last = last;
        in_padbytes = pad;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_message();
        rx_buf_pkg::conn_id_t  conn;
        logic                  open_flag;
        int                    beats;
        int                    len;
        rx_buf_pkg::padbytes_t pad;
        rx_buf_pkg::head_ptr_t ptr;
        rx_buf_pkg::buf_addr_t addr;
        rx_buf_pkg::mac_data_t data [$];
        conn = rx_buf_pkg::conn_id_t'($urandom % rx_buf_pkg::NUM_CONNS);
        open_flag = !conn_seen[conn] || ($urandom % 100 < 20);
        beats = 1 + int'($urandom % MAX_BEATS);
        pad = rx_buf_pkg::padbytes_t'($urandom);
        ptr = open_flag ? '0 : model_ptr[conn];
        for (int b = 0; b < beats; b++) begin
            data.push_back({$urandom, $urandom});
            // Later writers of the same word win.
            addr = {conn, ptr[8:3]};
            image[addr] = data[b];
            written[addr] = 1'b1;
            len = (b == beats - 1) ? rx_buf_pkg::MAC_BYTES - int'(pad) : rx_buf_pkg::MAC_BYTES;
            ptr = rx_buf_pkg::head_ptr_t'(int'(ptr) + len);
        end
        model_ptr[conn] = ptr;
        conn_seen[conn] = 1'b1;
        exp_conn_q.push_back(conn);
        exp_ptr_q.push_back(ptr);
        for (int b = 0; b < beats; b++) begin
            send_beat(conn, open_flag, data[b], b == beats - 1, pad);
        end
        in_valid = 1'b0;
    endtask

    task automatic read_buffer();
        rx_buf_pkg::buf_addr_t addr;
        for (int a = 0; a < rx_buf_pkg::BUF_DEPTH; a++) begin
            addr = rx_buf_pkg::buf_addr_t'(a);
            buf_rd_addr = addr;
            @(posedge clk);
            @(negedge clk);
            if (written[addr]) begin
                check_word(addr, buf_rd_data);
            end
            @(posedge clk);
            #1;
        end
    endtask

    // Handshakes are sampled at the falling edge before the edge that completes them.
    always @(negedge clk) begin
        if (!rst) begin
            // Five messages in flight means four queued and one held in ENQ.
            if (completed - popped > rx_buf_pkg::DESC_FIFO_DEPTH) begin
                full_cycles++;
                check_ready(in_ready, 1'b0);
            end
            if (desc_valid && desc_ready) begin
                check_desc(desc_conn_id, desc_head_ptr);
                popped++;
            end
            if (in_valid && in_ready && in_last) begin
                completed++;
            end
        end
    end

    initial begin
        int stall;
        desc_ready = 1'b0;
        // Long opening stall fills the FIFO.
        stall = 150;
        @(negedge rst);
        forever begin
            @(posedge clk);
            #1;
            if (draining) begin
                desc_ready = 1'b1;
            end else if (stall > 0) begin
                desc_ready = 1'b0;
                stall--;
            end else if ($urandom % 100 < 3) begin
                desc_ready = 1'b0;
                stall = 40 + int'($urandom % 81);
            end else begin
                desc_ready = ($urandom % 100 < 70);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish within %0d ns.", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        void'($urandom(32'hd0fa));
        rst = 1'b1;
        in_valid = 1'b0;
        in_conn_id = '0;
        in_conn_open = 1'b0;
        in_data = '0;
        in_last = 1'b0;
        in_padbytes = '0;
        buf_rd_addr = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int m = 0; m < NUM_MSGS; m++) begin
            send_message();
        end
        draining = 1'b1;
        wait (popped == NUM_MSGS);
        @(posedge clk);
        #1;
        read_buffer();
        if (full_cycles == 0) begin
            $display("The descriptor FIFO never filled, so back-pressure was not exercised.");
            abort_run();
        end else if (desc_valid) begin
            $display("An extra descriptor was left in the FIFO at the end of the run.");
            abort_run();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: verilog.f
rx_buf_pkg.sv
rx_buf_ptr_ram.sv
rx_buf_data_ram.sv
rx_buf_desc_fifo.sv
rx_buf_input_ctrl.sv
rx_buf_input_datap.sv
rx_buf_top.sv
tb_rx_buf.sv
